//--- flist.f
rtl/ctcq_cfg_pkg.sv
rtl/ctcq_op_pkg.sv
rtl/ctcq_entry.sv
rtl/ctcq_slot_mgr.sv
rtl/ctcq_launch.sv
rtl/ctcq_top.sv
tests/ctcq_tb.sv

//--- rtl/ctcq_cfg_pkg.sv
// sizing of the snoop maintenance queue and the widths of its fields
// addresses arrive as bits 39:4 of a 40-bit physical address
// the pointers are one-hot over the entries
package ctcq_cfg_pkg;

  // number of queue entries
  localparam int ENTRY_NUM = 6;

  // request fields from the snoop arbiter
  localparam int ASID_VA_W = 24;
  localparam int VA_PA_W   = 36;

  // fields handed to the tlb
  localparam int ASID_W    = 16;
  localparam int TLB_VA_W  = 27;

  // fields handed to the icache
  localparam int PTAG_W    = 28;
  localparam int IDX_W     = 6;

  // one bit per entry, one-hot when used as a pointer
  typedef logic [ENTRY_NUM-1:0] entry_vec_t;

endpackage

//--- rtl/ctcq_entry.sv
// one maintenance queue entry: idle, waiting for launch, complete
// a create while the entry is not idle is not allowed by the arbiter
// the stored request has no reset, only the life state does
`timescale 1ns/1ns

module ctcq_entry (
  input  logic                                ctcq_pe_clk,
  input  logic                                cpurst_b,
  input  logic                                create_en,
  input  ctcq_op_pkg::ctc_op_e                create_type,
  input  logic [ctcq_cfg_pkg::ASID_VA_W-1:0]  create_asid_va,
  input  logic [ctcq_cfg_pkg::VA_PA_W-1:0]    create_va_pa,
  input  logic                                inv_cmplt,
  input  logic                                inv_en,
  output logic                                vld,
  output logic                                pe_req,
  output logic                                cmplt,
  output logic                                create_rdy,
  output logic                                icache_all_inv,
  output logic                                icache_line_inv,
  output logic                                tlb_all_inv,
  output logic                                tlb_va_all_inv,
  output logic                                tlb_asid_all_inv,
  output logic                                tlb_va_asid_inv,
  output logic [ctcq_cfg_pkg::IDX_W-1:0]      icache_index,
  output logic [ctcq_cfg_pkg::PTAG_W-1:0]     icache_ptag,
  output logic [ctcq_cfg_pkg::ASID_W-1:0]     tlb_asid,
  output logic [ctcq_cfg_pkg::TLB_VA_W-1:0]   tlb_va
);

  import ctcq_cfg_pkg::*;
  import ctcq_op_pkg::*;

  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_wait  = 2'b01,
    st_cmplt = 2'b10
  } entry_st_e;

  entry_st_e              state;
  ctc_op_e                op_q;
  logic [ASID_W-1:0]      asid_q;
  logic [VA_PA_W-1:0]     va_pa_q;

  //**********************************************************
  // entry life
  //**********************************************************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= st_idle;
    else
    begin
      case (state)
        st_idle:  if (create_en) state <= st_wait;
        st_wait:  if (inv_cmplt) state <= st_cmplt;
        st_cmplt: if (inv_en)    state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  assign vld        = (state != st_idle);
  assign create_rdy = (state == st_idle);
  assign pe_req     = (state == st_wait);
  assign cmplt      = (state == st_cmplt);

  // request content, asid from top and low byte of asid_va
  always_ff @(posedge ctcq_pe_clk)
  begin
    if (create_en)
    begin
      op_q    <= create_type;
      asid_q  <= {create_asid_va[ASID_VA_W-1:ASID_VA_W-8], create_asid_va[7:0]};
      va_pa_q <= create_va_pa;
    end
  end

  //**********************************************************
  // opcode decode and field extraction
  //**********************************************************
  always_comb
  begin
    icache_all_inv   = 1'b0;
    icache_line_inv  = 1'b0;
    tlb_all_inv      = 1'b0;
    tlb_va_all_inv   = 1'b0;
    tlb_asid_all_inv = 1'b0;
    tlb_va_asid_inv  = 1'b0;
    case (op_q)
      ctcq_op_pkg::icache_all_inv:   icache_all_inv   = 1'b1;
      ctcq_op_pkg::icache_line_inv:  icache_line_inv  = 1'b1;
      ctcq_op_pkg::tlb_all_inv:      tlb_all_inv      = 1'b1;
      ctcq_op_pkg::tlb_va_all_inv:   tlb_va_all_inv   = 1'b1;
      ctcq_op_pkg::tlb_asid_all_inv: tlb_asid_all_inv = 1'b1;
      ctcq_op_pkg::tlb_va_asid_inv:  tlb_va_asid_inv  = 1'b1;
      default: ;
    endcase
  end

  // index is address bits 11:6, i.e. va_pa bits 7:2
  assign icache_index = va_pa_q[7:2];
  assign icache_ptag  = va_pa_q[VA_PA_W-1:8];
  assign tlb_va       = va_pa_q[TLB_VA_W-1:0];
  assign tlb_asid     = asid_q;

endmodule

//--- rtl/ctcq_launch.sv
// launches queue entries to the icache or tlb, one at a time in order
// a launch holds its strobe until the matching done pulse
// done pulses outside a launch are ignored
`timescale 1ns/1ns

module ctcq_launch (
  input  logic                               ctcq_pe_clk,
  input  logic                               cpurst_b,
  input  ctcq_cfg_pkg::entry_vec_t           entry_pe_req,
  input  ctcq_cfg_pkg::entry_vec_t           entry_icache_all_inv,
  input  ctcq_cfg_pkg::entry_vec_t           entry_icache_line_inv,
  input  ctcq_cfg_pkg::entry_vec_t           entry_tlb_all_inv,
  input  ctcq_cfg_pkg::entry_vec_t           entry_tlb_va_all_inv,
  input  ctcq_cfg_pkg::entry_vec_t           entry_tlb_asid_all_inv,
  input  ctcq_cfg_pkg::entry_vec_t           entry_tlb_va_asid_inv,
  input  logic [ctcq_cfg_pkg::IDX_W-1:0]     entry_icache_index [ctcq_cfg_pkg::ENTRY_NUM],
  input  logic [ctcq_cfg_pkg::PTAG_W-1:0]    entry_icache_ptag  [ctcq_cfg_pkg::ENTRY_NUM],
  input  logic [ctcq_cfg_pkg::ASID_W-1:0]    entry_tlb_asid     [ctcq_cfg_pkg::ENTRY_NUM],
  input  logic [ctcq_cfg_pkg::TLB_VA_W-1:0]  entry_tlb_va       [ctcq_cfg_pkg::ENTRY_NUM],
  input  logic                               ifu_lsu_icache_inv_done,
  input  logic                               mmu_lsu_tlb_inv_done,
  input  logic                               cp0_lsu_ctc_flush_dis,
  output ctcq_cfg_pkg::entry_vec_t           entry_inv_cmplt,
  output logic                               lsu_ifu_icache_all_inv,
  output logic                               lsu_ifu_icache_line_inv,
  output logic [ctcq_cfg_pkg::IDX_W-1:0]     lsu_ifu_icache_index,
  output logic [ctcq_cfg_pkg::PTAG_W-1:0]    lsu_ifu_icache_ptag,
  output logic                               lsu_mmu_tlb_all_inv,
  output logic                               lsu_mmu_tlb_va_all_inv,
  output logic                               lsu_mmu_tlb_asid_all_inv,
  output logic                               lsu_mmu_tlb_va_asid_inv,
  output logic [ctcq_cfg_pkg::ASID_W-1:0]    lsu_mmu_tlb_asid,
  output logic [ctcq_cfg_pkg::TLB_VA_W-1:0]  lsu_mmu_tlb_va,
  output logic                               lsu_rtu_ctc_flush_vld
);

  import ctcq_cfg_pkg::*;

  entry_vec_t          launch_ptr;
  logic                ctc_req;
  logic                launch_en;
  logic                done_vld;
  logic [5:0]          sel_flags;
  logic [5:0]          flags_q;
  logic [IDX_W-1:0]    sel_index;
  logic [PTAG_W-1:0]   sel_ptag;
  logic [ASID_W-1:0]   sel_asid;
  logic [TLB_VA_W-1:0] sel_va;
  logic                flush_q;

  //**********************************************************
  // select the entry at the launch pointer
  //**********************************************************
  // flag order: icache all, line, tlb all, va all, asid all, va asid
  assign sel_flags = {|(entry_tlb_va_asid_inv  & launch_ptr),
                      |(entry_tlb_asid_all_inv & launch_ptr),
                      |(entry_tlb_va_all_inv   & launch_ptr),
                      |(entry_tlb_all_inv      & launch_ptr),
                      |(entry_icache_line_inv  & launch_ptr),
                      |(entry_icache_all_inv   & launch_ptr)};

  always_comb
  begin
    sel_index = '0;
    sel_ptag  = '0;
    sel_asid  = '0;
    sel_va    = '0;
    for (int i = 0; i < ENTRY_NUM; i++)
    begin
      sel_index = sel_index | (entry_icache_index[i] & {IDX_W{launch_ptr[i]}});
      sel_ptag  = sel_ptag  | (entry_icache_ptag[i]  & {PTAG_W{launch_ptr[i]}});
      sel_asid  = sel_asid  | (entry_tlb_asid[i]     & {ASID_W{launch_ptr[i]}});
      sel_va    = sel_va    | (entry_tlb_va[i]       & {TLB_VA_W{launch_ptr[i]}});
    end
  end

  assign launch_en = !ctc_req && |(entry_pe_req & launch_ptr);
  assign done_vld  = ctc_req && (ifu_lsu_icache_inv_done || mmu_lsu_tlb_inv_done);

  //**********************************************************
  // request level, pointer and hold register
  //**********************************************************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ctc_req <= 1'b0;
    else if (done_vld)
      ctc_req <= 1'b0;
    else if (launch_en)
      ctc_req <= 1'b1;
  end

  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      launch_ptr <= entry_vec_t'(1);
    else if (done_vld)
      launch_ptr <= {launch_ptr[ENTRY_NUM-2:0], launch_ptr[ENTRY_NUM-1]};
  end

  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      flags_q <= 6'b0;
    else if (launch_en)
      flags_q <= sel_flags;
  end

  always_ff @(posedge ctcq_pe_clk)
  begin
    if (launch_en)
    begin
      lsu_ifu_icache_index <= sel_index;
      lsu_ifu_icache_ptag  <= sel_ptag;
      lsu_mmu_tlb_asid     <= sel_asid;
      lsu_mmu_tlb_va       <= sel_va;
    end
  end

  assign entry_inv_cmplt = {ENTRY_NUM{done_vld}} & launch_ptr;

  // strobes only while the request is out
  assign lsu_ifu_icache_all_inv   = ctc_req && flags_q[0];
  assign lsu_ifu_icache_line_inv  = ctc_req && flags_q[1];
  assign lsu_mmu_tlb_all_inv      = ctc_req && flags_q[2];
  assign lsu_mmu_tlb_va_all_inv   = ctc_req && flags_q[3];
  assign lsu_mmu_tlb_asid_all_inv = ctc_req && flags_q[4];
  assign lsu_mmu_tlb_va_asid_inv  = ctc_req && flags_q[5];

  //**********************************************************
  // async flush toward retire, one cycle after done
  //**********************************************************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      flush_q <= 1'b0;
    else
      flush_q <= done_vld && !cp0_lsu_ctc_flush_dis;
  end

  assign lsu_rtu_ctc_flush_vld = flush_q;

endmodule

//--- rtl/ctcq_op_pkg.sv
// maintenance opcodes as sent by the snoop arbiter
// any other encoding is not supported and launches no operation
package ctcq_op_pkg;

  typedef enum logic [5:0] {
    icache_all_inv   = 6'b000001,
    icache_line_inv  = 6'b000010,
    tlb_all_inv      = 6'b000100,
    tlb_va_all_inv   = 6'b001000,
    tlb_asid_all_inv = 6'b010000,
    tlb_va_asid_inv  = 6'b100000
  } ctc_op_e;

endpackage

//--- rtl/ctcq_slot_mgr.sv
// create pointer and response return for the maintenance queue
// oldest index comes one-hot from the arbiter, which keeps the order
// the arbiter must see cur_ctcq_entry_empty high before a create
`timescale 1ns/1ns

module ctcq_slot_mgr (
  input  logic                     ctcq_pe_clk,
  input  logic                     cpurst_b,
  input  logic                     ctc_req_create_en,
  input  ctcq_cfg_pkg::entry_vec_t entry_create_rdy,
  input  ctcq_cfg_pkg::entry_vec_t entry_vld,
  input  ctcq_cfg_pkg::entry_vec_t entry_cmplt,
  input  ctcq_cfg_pkg::entry_vec_t arb_ctcq_entry_oldest_index,
  input  logic                     biu_ctcq_cr_ready,
  output ctcq_cfg_pkg::entry_vec_t entry_create_en,
  output ctcq_cfg_pkg::entry_vec_t entry_inv_en,
  output logic                     cur_ctcq_entry_empty,
  output logic                     lsu_ctcq_not_empty,
  output logic                     ctcq_biu_cr_valid
);

  import ctcq_cfg_pkg::*;

  entry_vec_t create_ptr;
  entry_vec_t resp_idx;

  //**********************************************************
  // create pointer, one-hot, rotates per create
  //**********************************************************
  always_ff @(posedge ctcq_pe_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      create_ptr <= entry_vec_t'(1);
    else if (ctc_req_create_en)
      create_ptr <= {create_ptr[ENTRY_NUM-2:0], create_ptr[ENTRY_NUM-1]};
  end

  assign entry_create_en      = {ENTRY_NUM{ctc_req_create_en}} & create_ptr;
  assign cur_ctcq_entry_empty = |(create_ptr & entry_create_rdy);
  assign lsu_ctcq_not_empty   = |entry_vld;

  //**********************************************************
  // response to the bus
  //**********************************************************
  assign resp_idx          = entry_cmplt & arb_ctcq_entry_oldest_index;
  assign ctcq_biu_cr_valid = |resp_idx;

  // accepted response frees its entry
  assign entry_inv_en = {ENTRY_NUM{biu_ctcq_cr_ready}} & resp_idx;

endmodule

//--- rtl/ctcq_top.sv
// snoop path cache and tlb maintenance queue, six entries
// single clock domain, asynchronous active-low reset
// arbiter creates only while cur_ctcq_entry_empty is high
`timescale 1ns/1ns

module ctcq_top (
  input  logic                               ctcq_pe_clk,
  input  logic                               cpurst_b,
  input  logic                               ctc_req_create_en,
  input  ctcq_op_pkg::ctc_op_e               arb_ctcq_ctc_type,
  input  logic [ctcq_cfg_pkg::ASID_VA_W-1:0] arb_ctcq_ctc_asid_va,
  input  logic [ctcq_cfg_pkg::VA_PA_W-1:0]   arb_ctcq_ctc_va_pa,
  input  ctcq_cfg_pkg::entry_vec_t           arb_ctcq_entry_oldest_index,
  input  logic                               biu_ctcq_cr_ready,
  input  logic                               cp0_lsu_ctc_flush_dis,
  input  logic                               ifu_lsu_icache_inv_done,
  input  logic                               mmu_lsu_tlb_inv_done,
  output logic                               ctcq_biu_cr_valid,
  output logic                               cur_ctcq_entry_empty,
  output logic                               lsu_ctcq_not_empty,
  output logic                               lsu_ifu_icache_all_inv,
  output logic                               lsu_ifu_icache_line_inv,
  output logic [ctcq_cfg_pkg::IDX_W-1:0]     lsu_ifu_icache_index,
  output logic [ctcq_cfg_pkg::PTAG_W-1:0]    lsu_ifu_icache_ptag,
  output logic                               lsu_mmu_tlb_all_inv,
  output logic                               lsu_mmu_tlb_va_all_inv,
  output logic                               lsu_mmu_tlb_asid_all_inv,
  output logic                               lsu_mmu_tlb_va_asid_inv,
  output logic [ctcq_cfg_pkg::ASID_W-1:0]    lsu_mmu_tlb_asid,
  output logic [ctcq_cfg_pkg::TLB_VA_W-1:0]  lsu_mmu_tlb_va,
  output logic                               lsu_rtu_ctc_flush_vld
);

  import ctcq_cfg_pkg::*;

  entry_vec_t          entry_create_en;
  entry_vec_t          entry_inv_en;
  entry_vec_t          entry_inv_cmplt;
  entry_vec_t          entry_vld;
  entry_vec_t          entry_pe_req;
  entry_vec_t          entry_cmplt;
  entry_vec_t          entry_create_rdy;
  entry_vec_t          entry_icache_all_inv;
  entry_vec_t          entry_icache_line_inv;
  entry_vec_t          entry_tlb_all_inv;
  entry_vec_t          entry_tlb_va_all_inv;
  entry_vec_t          entry_tlb_asid_all_inv;
  entry_vec_t          entry_tlb_va_asid_inv;
  logic [IDX_W-1:0]    entry_icache_index [ENTRY_NUM];
  logic [PTAG_W-1:0]   entry_icache_ptag  [ENTRY_NUM];
  logic [ASID_W-1:0]   entry_tlb_asid     [ENTRY_NUM];
  logic [TLB_VA_W-1:0] entry_tlb_va       [ENTRY_NUM];

  //**********************************************************
  // queue entries
  //**********************************************************
  for (genvar i = 0; i < ENTRY_NUM; i++)
  begin : g_entry
    ctcq_entry u_entry (
      .ctcq_pe_clk      (ctcq_pe_clk),
      .cpurst_b         (cpurst_b),
      .create_en        (entry_create_en[i]),
      .create_type      (arb_ctcq_ctc_type),
      .create_asid_va   (arb_ctcq_ctc_asid_va),
      .create_va_pa     (arb_ctcq_ctc_va_pa),
      .inv_cmplt        (entry_inv_cmplt[i]),
      .inv_en           (entry_inv_en[i]),
      .vld              (entry_vld[i]),
      .pe_req           (entry_pe_req[i]),
      .cmplt            (entry_cmplt[i]),
      .create_rdy       (entry_create_rdy[i]),
      .icache_all_inv   (entry_icache_all_inv[i]),
      .icache_line_inv  (entry_icache_line_inv[i]),
      .tlb_all_inv      (entry_tlb_all_inv[i]),
      .tlb_va_all_inv   (entry_tlb_va_all_inv[i]),
      .tlb_asid_all_inv (entry_tlb_asid_all_inv[i]),
      .tlb_va_asid_inv  (entry_tlb_va_asid_inv[i]),
      .icache_index     (entry_icache_index[i]),
      .icache_ptag      (entry_icache_ptag[i]),
      .tlb_asid         (entry_tlb_asid[i]),
      .tlb_va           (entry_tlb_va[i])
    );
  end

  //**********************************************************
  // create and return
  //**********************************************************
  ctcq_slot_mgr u_slot_mgr (
    .ctcq_pe_clk                 (ctcq_pe_clk),
    .cpurst_b                    (cpurst_b),
    .ctc_req_create_en           (ctc_req_create_en),
    .entry_create_rdy            (entry_create_rdy),
    .entry_vld                   (entry_vld),
    .entry_cmplt                 (entry_cmplt),
    .arb_ctcq_entry_oldest_index (arb_ctcq_entry_oldest_index),
    .biu_ctcq_cr_ready           (biu_ctcq_cr_ready),
    .entry_create_en             (entry_create_en),
    .entry_inv_en                (entry_inv_en),
    .cur_ctcq_entry_empty        (cur_ctcq_entry_empty),
    .lsu_ctcq_not_empty          (lsu_ctcq_not_empty),
    .ctcq_biu_cr_valid           (ctcq_biu_cr_valid)
  );

  //**********************************************************
  // launch toward icache and tlb
  //**********************************************************
  ctcq_launch u_launch (
    .ctcq_pe_clk              (ctcq_pe_clk),
    .cpurst_b                 (cpurst_b),
    .entry_pe_req             (entry_pe_req),
    .entry_icache_all_inv     (entry_icache_all_inv),
    .entry_icache_line_inv    (entry_icache_line_inv),
    .entry_tlb_all_inv        (entry_tlb_all_inv),
    .entry_tlb_va_all_inv     (entry_tlb_va_all_inv),
    .entry_tlb_asid_all_inv   (entry_tlb_asid_all_inv),
    .entry_tlb_va_asid_inv    (entry_tlb_va_asid_inv),
    .entry_icache_index       (entry_icache_index),
    .entry_icache_ptag        (entry_icache_ptag),
    .entry_tlb_asid           (entry_tlb_asid),
    .entry_tlb_va             (entry_tlb_va),
    .ifu_lsu_icache_inv_done  (ifu_lsu_icache_inv_done),
    .mmu_lsu_tlb_inv_done     (mmu_lsu_tlb_inv_done),
    .cp0_lsu_ctc_flush_dis    (cp0_lsu_ctc_flush_dis),
    .entry_inv_cmplt          (entry_inv_cmplt),
    .lsu_ifu_icache_all_inv   (lsu_ifu_icache_all_inv),
    .lsu_ifu_icache_line_inv  (lsu_ifu_icache_line_inv),
    .lsu_ifu_icache_index     (lsu_ifu_icache_index),
    .lsu_ifu_icache_ptag      (lsu_ifu_icache_ptag),
    .lsu_mmu_tlb_all_inv      (lsu_mmu_tlb_all_inv),
    .lsu_mmu_tlb_va_all_inv   (lsu_mmu_tlb_va_all_inv),
    .lsu_mmu_tlb_asid_all_inv (lsu_mmu_tlb_asid_all_inv),
    .lsu_mmu_tlb_va_asid_inv  (lsu_mmu_tlb_va_asid_inv),
    .lsu_mmu_tlb_asid         (lsu_mmu_tlb_asid),
    .lsu_mmu_tlb_va           (lsu_mmu_tlb_va),
    .lsu_rtu_ctc_flush_vld    (lsu_rtu_ctc_flush_vld)
  );

endmodule

//--- run.sh
#!/bin/sh
# builds the maintenance queue testbench with Verilator and runs it
# the exit status is the simulator's, non-zero on any failing end
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module ctcq_tb -o ctcq_sim &&
./obj_dir/ctcq_sim || { echo "simulation did not pass"; exit 1; }

//--- tests/ctcq_tb.sv
// testbench for the maintenance queue, inputs change on the falling edge
// one request row at a time, then all six entries filled and a wrap to entry 0
// the arbiter's oldest order is kept as a queue of entry numbers
// random done and ready delays use a fixed seed
`timescale 1ns/1ns

module ctcq_tb;

  import ctcq_cfg_pkg::*;
  import ctcq_op_pkg::*;

  localparam int ROW_NUM     = 6;
  localparam int MAX_DLY     = 6;
  localparam int PERIOD      = 100;
  // every launch plus its response, worst case, plus reset and a margin
  localparam int WATCHDOG_NS = ((2 * ROW_NUM + 1) * (2 * MAX_DLY + 8) + 60) * PERIOD;

  typedef struct packed {
    ctc_op_e                op;
    logic [ASID_VA_W-1:0]   asid_va;
    logic [VA_PA_W-1:0]     va_pa;
    logic                   flush_dis;
    int                     done_dly;
    int                     ready_dly;
  } row_t;

  logic                 ctcq_pe_clk = 1'b0;
  logic                 cpurst_b;
  logic                 ctc_req_create_en;
  ctc_op_e              arb_ctcq_ctc_type;
  logic [ASID_VA_W-1:0] arb_ctcq_ctc_asid_va;
  logic [VA_PA_W-1:0]   arb_ctcq_ctc_va_pa;
  entry_vec_t           arb_ctcq_entry_oldest_index;
  logic                 biu_ctcq_cr_ready;
  logic                 cp0_lsu_ctc_flush_dis;
  logic                 ifu_lsu_icache_inv_done;
  logic                 mmu_lsu_tlb_inv_done;
  logic                 ctcq_biu_cr_valid;
  logic                 cur_ctcq_entry_empty;
  logic                 lsu_ctcq_not_empty;
  logic                 icache_all;
  logic                 icache_line;
  logic [IDX_W-1:0]     icache_index;
  logic [PTAG_W-1:0]    icache_ptag;
  logic                 tlb_all;
  logic                 tlb_va_all;
  logic                 tlb_asid_all;
  logic                 tlb_va_asid;
  logic [ASID_W-1:0]    tlb_asid;
  logic [TLB_VA_W-1:0]  tlb_va;
  logic                 flush_vld;
  logic [5:0]           strobes;

  row_t                 rows [ROW_NUM];
  int                   order_q [$];
  int                   create_slot;

  ctcq_top UUT (
    .ctcq_pe_clk                 (ctcq_pe_clk),
    .cpurst_b                    (cpurst_b),
    .ctc_req_create_en           (ctc_req_create_en),
    .arb_ctcq_ctc_type           (arb_ctcq_ctc_type),
    .arb_ctcq_ctc_asid_va        (arb_ctcq_ctc_asid_va),
    .arb_ctcq_ctc_va_pa          (arb_ctcq_ctc_va_pa),
    .arb_ctcq_entry_oldest_index (arb_ctcq_entry_oldest_index),
    .biu_ctcq_cr_ready           (biu_ctcq_cr_ready),
    .cp0_lsu_ctc_flush_dis       (cp0_lsu_ctc_flush_dis),
    .ifu_lsu_icache_inv_done     (ifu_lsu_icache_inv_done),
    .mmu_lsu_tlb_inv_done        (mmu_lsu_tlb_inv_done),
    .ctcq_biu_cr_valid           (ctcq_biu_cr_valid),
    .cur_ctcq_entry_empty        (cur_ctcq_entry_empty),
    .lsu_ctcq_not_empty          (lsu_ctcq_not_empty),
    .lsu_ifu_icache_all_inv      (icache_all),
    .lsu_ifu_icache_line_inv     (icache_line),
    .lsu_ifu_icache_index        (icache_index),
    .lsu_ifu_icache_ptag         (icache_ptag),
    .lsu_mmu_tlb_all_inv         (tlb_all),
    .lsu_mmu_tlb_va_all_inv      (tlb_va_all),
    .lsu_mmu_tlb_asid_all_inv    (tlb_asid_all),
    .lsu_mmu_tlb_va_asid_inv     (tlb_va_asid),
    .lsu_mmu_tlb_asid            (tlb_asid),
    .lsu_mmu_tlb_va              (tlb_va),
    .lsu_rtu_ctc_flush_vld       (flush_vld)
  );

  assign strobes = {tlb_va_asid, tlb_asid_all, tlb_va_all, tlb_all, icache_line, icache_all};

  always
  begin
    #(PERIOD/2) ctcq_pe_clk = ~ctcq_pe_clk;
  end

  // strobe pattern in the order of the strobes vector
  function automatic logic [5:0] exp_strobes(input ctc_op_e op);
    case (op)
      icache_all_inv:   return 6'b000001;
      icache_line_inv:  return 6'b000010;
      tlb_all_inv:      return 6'b000100;
      tlb_va_all_inv:   return 6'b001000;
      tlb_asid_all_inv: return 6'b010000;
      default:          return 6'b100000;
    endcase
  endfunction

  task automatic expect_that(input logic ok, input string msg);
    assert (ok)
    else
    begin
      $display("mismatch at %0t ns: %s", $time, msg);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic next_fall();
    @(negedge ctcq_pe_clk);
  endtask

  task automatic set_row(input int i, input ctc_op_e op, input logic [ASID_VA_W-1:0] asid_va,
                         input logic [VA_PA_W-1:0] va_pa, input logic flush_dis);
    rows[i].op        = op;
    rows[i].asid_va   = asid_va;
    rows[i].va_pa     = va_pa;
    rows[i].flush_dis = flush_dis;
    rows[i].done_dly  = $urandom % MAX_DLY;
    rows[i].ready_dly = $urandom % MAX_DLY;
  endtask

  task automatic point_oldest();
    if (order_q.size() > 0)
      arb_ctcq_entry_oldest_index = entry_vec_t'(1) << order_q[0];
    else
      arb_ctcq_entry_oldest_index = '0;
  endtask

  // arbiter side, one create strobe
  task automatic create_req(input row_t r);
    expect_that(cur_ctcq_entry_empty, "create slot not free");
    ctc_req_create_en    = 1'b1;
    arb_ctcq_ctc_type    = r.op;
    arb_ctcq_ctc_asid_va = r.asid_va;
    arb_ctcq_ctc_va_pa   = r.va_pa;
    order_q.push_back(create_slot);
    create_slot = (create_slot + 1) % ENTRY_NUM;
    point_oldest();
    next_fall();
    ctc_req_create_en = 1'b0;
    expect_that(lsu_ctcq_not_empty, "not_empty low after create");
  endtask

  task automatic check_strobe(input row_t r);
    expect_that(strobes == exp_strobes(r.op), "wrong strobe for opcode");
    expect_that(icache_index == r.va_pa[7:2], "icache index");
    expect_that(icache_ptag == r.va_pa[35:8], "icache ptag");
    expect_that(tlb_va == r.va_pa[TLB_VA_W-1:0], "tlb va");
    expect_that(tlb_asid == {r.asid_va[23:16], r.asid_va[7:0]}, "tlb asid");
  endtask

  // icache or tlb model, done after the row's delay
  task automatic finish_inv(input row_t r);
    repeat (r.done_dly)
    begin
      next_fall();
      expect_that(strobes == exp_strobes(r.op), "strobe dropped before done");
    end
    if (r.op == icache_all_inv || r.op == icache_line_inv)
      ifu_lsu_icache_inv_done = 1'b1;
    else
      mmu_lsu_tlb_inv_done = 1'b1;
    cp0_lsu_ctc_flush_dis = r.flush_dis;
    next_fall();
    ifu_lsu_icache_inv_done = 1'b0;
    mmu_lsu_tlb_inv_done    = 1'b0;
    cp0_lsu_ctc_flush_dis   = 1'b0;
    expect_that(strobes == 6'b0, "strobe still high after done");
    expect_that(flush_vld == !r.flush_dis, "flush after done");
    expect_that(ctcq_biu_cr_valid, "cr_valid low one cycle after done");
    next_fall();
    expect_that(!flush_vld, "flush longer than one cycle");
  endtask

  // bus model, ready after a delay, then one idle cycle
  task automatic accept_resp(input int dly);
    repeat (dly)
    begin
      expect_that(ctcq_biu_cr_valid, "cr_valid dropped while ready low");
      next_fall();
    end
    expect_that(ctcq_biu_cr_valid, "cr_valid low at acceptance");
    biu_ctcq_cr_ready = 1'b1;
    next_fall();
    biu_ctcq_cr_ready = 1'b0;
    void'(order_q.pop_front());
    point_oldest();
    next_fall();
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $fatal(1);
  end

  initial
  begin
    void'($urandom(7));
    cpurst_b                    = 1'b0;
    ctc_req_create_en           = 1'b0;
    arb_ctcq_ctc_type           = icache_all_inv;
    arb_ctcq_ctc_asid_va        = '0;
    arb_ctcq_ctc_va_pa          = '0;
    arb_ctcq_entry_oldest_index = '0;
    biu_ctcq_cr_ready           = 1'b0;
    cp0_lsu_ctc_flush_dis       = 1'b0;
    ifu_lsu_icache_inv_done     = 1'b0;
    mmu_lsu_tlb_inv_done        = 1'b0;
    create_slot                 = 0;
    set_row(0, icache_all_inv,   24'h123456, 36'h012345678, 1'b0);
    set_row(1, icache_line_inv,  24'hA5003C, 36'hFEDCBA9F4, 1'b1);
    set_row(2, tlb_all_inv,      24'h00FF00, 36'h800000FFC, 1'b0);
    set_row(3, tlb_va_all_inv,   24'h7E1181, 36'h3C3C3C3C0, 1'b0);
    set_row(4, tlb_asid_all_inv, 24'hFFAA01, 36'h555555554, 1'b1);
    set_row(5, tlb_va_asid_inv,  24'h9B642D, 36'hC0FFEE010, 1'b0);
    repeat (16) next_fall();
    cpurst_b = 1'b1;
    expect_that(strobes == 6'b0 && !ctcq_biu_cr_valid && !flush_vld, "outputs after reset");
    expect_that(!lsu_ctcq_not_empty && cur_ctcq_entry_empty, "queue state after reset");

    //**********************************************************
    // one request at a time
    //**********************************************************
    for (int i = 0; i < ROW_NUM; i++)
    begin
      create_req(rows[i]);
      expect_that(strobes == 6'b0, "strobe one edge after create");
      next_fall();
      check_strobe(rows[i]);
      expect_that(!ctcq_biu_cr_valid, "cr_valid before done");
      finish_inv(rows[i]);
      accept_resp(rows[i].ready_dly);
      expect_that(!lsu_ctcq_not_empty, "not_empty after response");
    end

    //**********************************************************
    // fill all entries, free entry 0, wrap
    //**********************************************************
    for (int i = 0; i < ENTRY_NUM; i++)
      create_req(rows[i]);
    expect_that(!cur_ctcq_entry_empty, "queue full but create slot free");
    check_strobe(rows[0]);
    finish_inv(rows[0]);
    for (int i = 1; i < ENTRY_NUM; i++)
    begin
      check_strobe(rows[i]);
      finish_inv(rows[i]);
    end
    expect_that(!cur_ctcq_entry_empty, "entry 0 free before acceptance");
    accept_resp(0);
    expect_that(cur_ctcq_entry_empty, "entry 0 not free after acceptance");
    expect_that(ctcq_biu_cr_valid, "next oldest not reported");
    create_req(rows[3]);
    expect_that(strobes == 6'b0, "wrapped strobe one edge after create");
    next_fall();
    check_strobe(rows[3]);
    finish_inv(rows[3]);
    for (int i = 0; i < ENTRY_NUM; i++)
      accept_resp(rows[i].ready_dly);
    expect_that(!lsu_ctcq_not_empty && cur_ctcq_entry_empty, "queue not drained");
    $display("TESTS PASSED");
    $finish;
  end

endmodule
